//--- verilog/fetch_macros.svh
`ifndef FETCH_MACROS_SVH
`define FETCH_MACROS_SVH

// reset fetch address, in kseg1.
`define FETCH_RESET_PC      32'hbfc0_0000
`define FETCH_RESET_PADDR   32'h1fc0_0000

// top three address bits of the unmapped segments.
`define FETCH_SEG_KSEG0     3'b100
`define FETCH_SEG_KSEG1     3'b101

`define FETCH_TLB_ENTRIES   8
`define FETCH_TLB_INDEX_W   3

// memory is indexed by physical address bits 9 to 2.
`define FETCH_MEM_WORDS     256
`define FETCH_MEM_ADDR_W    8

`define FETCH_QUEUE_DEPTH   8

`endif

//--- verilog/fetch_pkg.sv
package fetch_pkg;

    // segment view of a virtual address.
    typedef struct packed {
        logic [2:0]  seg;
        logic [28:0] offset;
    } seg_view_t;

    // page view of a virtual address.
    typedef struct packed {
        logic [19:0] vpn;
        logic [11:0] page_off;
    } page_view_t;

    typedef union packed {
        seg_view_t  seg;
        page_view_t page;
    } vaddr_t;

    typedef struct packed {
        logic [19:0] vpn;
        logic [19:0] pfn;
        logic        valid;
        logic        cached;
    } tlb_entry_t;

    typedef enum logic [1:0] {
        FAULT_NONE    = 2'd0,
        FAULT_MISS    = 2'd1,
        FAULT_INVALID = 2'd2,
        FAULT_ILLEGAL = 2'd3
    } fault_kind_t;

endpackage

//--- verilog/tlb_port_if.sv
`timescale 1ns/1ps

// one lookup port, result valid in the same cycle as the address.
interface tlb_port_if;
    logic [31:0] vaddr;
    logic [31:0] paddr;
    logic        miss;
    logic        illegal;
    logic        invalid;
    logic        uncached;

    modport requester (
        output vaddr,
        input  paddr, miss, illegal, invalid, uncached
    );

    modport translator (
        input  vaddr,
        output paddr, miss, illegal, invalid, uncached
    );

endinterface

//--- verilog/pc.sv
`timescale 1ns/1ps
`include "fetch_macros.svh"

module pc (
    input  logic                   clk,
    input  logic                   rst,
    input  logic                   pc_en,
    input  logic                   inst_ok_1,
    input  logic                   inst_ok_2,
    input  logic                   fifo_full,

    input  logic                   branch_taken,
    input  logic [31:0]            branch_address,
    input  logic                   exception_taken,
    input  logic [31:0]            exception_address,

    tlb_port_if.requester          bran_port,
    tlb_port_if.requester          seq0_port,
    tlb_port_if.requester          seq1_port,

    output logic [31:0]            pc_address,
    output logic [31:0]            pc_address_psy,
    output logic                   tlb_miss,
    output logic                   tlb_illegal,
    output logic                   tlb_invalid,
    output logic                   tlb_uncached
);

    fetch_pkg::vaddr_t exc_va;

    logic [31:0] pc_next;
    logic [31:0] psy_next;
    logic        miss_next;
    logic        illegal_next;
    logic        invalid_next;
    logic        uncached_next;

    assign exc_va = exception_address;

    // candidates offered to the itlb.
    assign bran_port.vaddr = branch_address;
    assign seq0_port.vaddr = pc_address + 32'd4;
    assign seq1_port.vaddr = pc_address + 32'd8;

    always_comb begin
        pc_next       = pc_address;
        psy_next      = pc_address_psy;
        miss_next     = tlb_miss;
        illegal_next  = tlb_illegal;
        invalid_next  = tlb_invalid;
        uncached_next = tlb_uncached;
        if (pc_en) begin
            if (exception_taken) begin
                // vectors live in kseg0/kseg1, so strip the segment bits.
                pc_next       = exception_address;
                psy_next      = {3'b000, exc_va.seg.offset};
                miss_next     = 1'b0;
                illegal_next  = (exception_address[1:0] != 2'b00);
                invalid_next  = 1'b0;
                uncached_next = exc_va.seg.seg[0];
            end else if (branch_taken) begin
                pc_next       = branch_address;
                psy_next      = bran_port.paddr;
                miss_next     = bran_port.miss;
                illegal_next  = bran_port.illegal;
                invalid_next  = bran_port.invalid;
                uncached_next = bran_port.uncached;
            end else if (fifo_full) begin
                // hold.
                pc_next = pc_address;
            end else if (inst_ok_1 && inst_ok_2) begin
                pc_next       = seq1_port.vaddr;
                psy_next      = seq1_port.paddr;
                miss_next     = seq1_port.miss;
                illegal_next  = seq1_port.illegal;
                invalid_next  = seq1_port.invalid;
                uncached_next = seq1_port.uncached;
            end else if (inst_ok_1) begin
                pc_next       = seq0_port.vaddr;
                psy_next      = seq0_port.paddr;
                miss_next     = seq0_port.miss;
                illegal_next  = seq0_port.illegal;
                invalid_next  = seq0_port.invalid;
                uncached_next = seq0_port.uncached;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            pc_address     <= `FETCH_RESET_PC;
            pc_address_psy <= `FETCH_RESET_PADDR;
            tlb_miss       <= 1'b0;
            tlb_illegal    <= 1'b0;
            tlb_invalid    <= 1'b0;
            tlb_uncached   <= 1'b1;
        end else begin
            pc_address     <= pc_next;
            pc_address_psy <= psy_next;
            tlb_miss       <= miss_next;
            tlb_illegal    <= illegal_next;
            tlb_invalid    <= invalid_next;
            tlb_uncached   <= uncached_next;
        end
    end

    // an unaligned pc must always come with the illegal flag from the itlb.
    pc_aligned_a: assert property (
        @(posedge clk) disable iff (rst)
        !tlb_illegal |-> (pc_address[1:0] == 2'b00)
    );

endmodule

//--- verilog/itlb.sv
`timescale 1ns/1ps
`include "fetch_macros.svh"

module itlb (
    input  logic                          clk,
    input  logic                          rst,
    input  logic                          we,
    input  logic [`FETCH_TLB_INDEX_W-1:0] index,
    input  fetch_pkg::tlb_entry_t         entry,

    tlb_port_if.translator                bran_port,
    tlb_port_if.translator                seq0_port,
    tlb_port_if.translator                seq1_port
);

    fetch_pkg::tlb_entry_t tlb_table [`FETCH_TLB_ENTRIES];

    logic [31:0] va [3];
    logic [31:0] pa [3];
    logic [2:0]  miss;
    logic [2:0]  illegal;
    logic [2:0]  invalid;
    logic [2:0]  uncached;

    // reset tags point above kuseg so no lookup hits an unwritten entry.
    always_ff @(posedge clk) begin
        if (rst) begin
            for (int e = 0; e < `FETCH_TLB_ENTRIES; e++) begin
                tlb_table[e] <= '{vpn: 20'h80000 | 20'(e), pfn: 20'h0,
                                  valid: 1'b0, cached: 1'b0};
            end
        end else if (we) begin
            tlb_table[index] <= entry;
        end
    end

    assign va[0] = bran_port.vaddr;
    assign va[1] = seq0_port.vaddr;
    assign va[2] = seq1_port.vaddr;

    for (genvar p = 0; p < 3; p++) begin : g_port
        fetch_pkg::vaddr_t             v;
        fetch_pkg::tlb_entry_t         sel;
        logic [`FETCH_TLB_ENTRIES-1:0] hit;

        assign v = va[p];

        for (genvar e = 0; e < `FETCH_TLB_ENTRIES; e++) begin : g_cmp
            assign hit[e] = (tlb_table[e].vpn == v.page.vpn);
        end

        always_comb begin
            sel         = '0;
            pa[p]       = {3'b000, v.seg.offset};
            miss[p]     = 1'b0;
            illegal[p]  = 1'b0;
            invalid[p]  = 1'b0;
            uncached[p] = 1'b0;
            for (int e = 0; e < `FETCH_TLB_ENTRIES; e++) begin
                if (hit[e]) sel = tlb_table[e];
            end
            if (v.page.page_off[1:0] != 2'b00) begin
                illegal[p] = 1'b1;
            end else if (v.seg.seg == `FETCH_SEG_KSEG0) begin
                uncached[p] = 1'b0;
            end else if (v.seg.seg == `FETCH_SEG_KSEG1) begin
                uncached[p] = 1'b1;
            end else if (v.seg.seg[2]) begin
                // kseg2 and kseg3.
                illegal[p] = 1'b1;
            end else if (hit == '0) begin
                miss[p] = 1'b1;
            end else if (!sel.valid) begin
                invalid[p] = 1'b1;
            end else begin
                pa[p]       = {sel.pfn, v.page.page_off};
                uncached[p] = !sel.cached;
            end
        end

        // duplicate tags written by software would make the lookup ambiguous.
        tlb_unique_hit_a: assert property (
            @(posedge clk) disable iff (rst) $onehot0(hit)
        );
    end

    assign bran_port.paddr    = pa[0];
    assign bran_port.miss     = miss[0];
    assign bran_port.illegal  = illegal[0];
    assign bran_port.invalid  = invalid[0];
    assign bran_port.uncached = uncached[0];

    assign seq0_port.paddr    = pa[1];
    assign seq0_port.miss     = miss[1];
    assign seq0_port.illegal  = illegal[1];
    assign seq0_port.invalid  = invalid[1];
    assign seq0_port.uncached = uncached[1];

    assign seq1_port.paddr    = pa[2];
    assign seq1_port.miss     = miss[2];
    assign seq1_port.illegal  = illegal[2];
    assign seq1_port.invalid  = invalid[2];
    assign seq1_port.uncached = uncached[2];

endmodule

//--- verilog/inst_fetch.sv
`timescale 1ns/1ps
`include "fetch_macros.svh"

module inst_fetch (
    input  logic                         clk,
    input  logic                         mem_we,
    input  logic [`FETCH_MEM_ADDR_W-1:0] mem_addr,
    input  logic [31:0]                  mem_wdata,
    input  logic [31:0]                  pc_address,
    input  logic [31:0]                  pc_address_psy,
    input  logic                         tlb_miss,
    input  logic                         tlb_illegal,
    input  logic                         tlb_invalid,

    output logic                         inst_ok_1,
    output logic                         inst_ok_2,
    output logic [31:0]                  inst_word_0,
    output logic [31:0]                  inst_word_1,
    output logic                         fetch_fault,
    output fetch_pkg::fault_kind_t       fault_kind
);

    logic [31:0]                  mem [`FETCH_MEM_WORDS];
    logic [`FETCH_MEM_ADDR_W-1:0] rd_idx;

    always_ff @(posedge clk) begin
        if (mem_we) mem[mem_addr] <= mem_wdata;
    end

    assign rd_idx      = pc_address_psy[`FETCH_MEM_ADDR_W+1:2];
    assign inst_word_0 = mem[rd_idx];
    // second word of the aligned pair.
    assign inst_word_1 = mem[{rd_idx[`FETCH_MEM_ADDR_W-1:1], 1'b1}];

    assign inst_ok_1   = !(tlb_miss || tlb_invalid || tlb_illegal);
    assign inst_ok_2   = inst_ok_1 && !pc_address[2];
    assign fetch_fault = !inst_ok_1;

    always_comb begin
        if (tlb_illegal)      fault_kind = fetch_pkg::FAULT_ILLEGAL;
        else if (tlb_miss)    fault_kind = fetch_pkg::FAULT_MISS;
        else if (tlb_invalid) fault_kind = fetch_pkg::FAULT_INVALID;
        else                  fault_kind = fetch_pkg::FAULT_NONE;
    end

endmodule

//--- verilog/fetch_queue.sv
`timescale 1ns/1ps
`include "fetch_macros.svh"

module fetch_queue (
    input  logic        clk,
    input  logic        rst,
    input  logic        push_1,
    input  logic        push_2,
    input  logic        flush,
    input  logic [31:0] pc_0,
    input  logic [31:0] word_0,
    input  logic [31:0] word_1,
    input  logic        deq,

    output logic        fifo_full,
    output logic        inst_valid,
    output logic [31:0] inst_pc,
    output logic [31:0] inst_word
);

    localparam int PTR_W = $clog2(`FETCH_QUEUE_DEPTH);
    localparam int CNT_W = $clog2(`FETCH_QUEUE_DEPTH + 1);

    logic [31:0]      pc_mem   [`FETCH_QUEUE_DEPTH];
    logic [31:0]      word_mem [`FETCH_QUEUE_DEPTH];
    logic [PTR_W-1:0] wr_ptr;
    logic [PTR_W-1:0] wr_ptr_1;
    logic [PTR_W-1:0] rd_ptr;
    logic [CNT_W-1:0] count;
    logic             do_push_1;
    logic             do_push_2;
    logic             do_pop;

    // full means no room for a pair.
    assign fifo_full  = (count > CNT_W'(`FETCH_QUEUE_DEPTH - 2));
    assign inst_valid = (count != '0);
    assign inst_pc    = pc_mem[rd_ptr];
    assign inst_word  = word_mem[rd_ptr];

    assign do_push_1 = push_1 && !fifo_full && !flush;
    assign do_push_2 = do_push_1 && push_2;
    assign do_pop    = deq && inst_valid;
    assign wr_ptr_1  = wr_ptr + 1'b1;

    always_ff @(posedge clk) begin
        if (do_push_1) begin
            pc_mem[wr_ptr]   <= pc_0;
            word_mem[wr_ptr] <= word_0;
        end
        if (do_push_2) begin
            pc_mem[wr_ptr_1]   <= pc_0 + 32'd4;
            word_mem[wr_ptr_1] <= word_1;
        end
    end

    always_ff @(posedge clk) begin
        if (rst || flush) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            wr_ptr <= wr_ptr + PTR_W'(do_push_1) + PTR_W'(do_push_2);
            rd_ptr <= rd_ptr + PTR_W'(do_pop);
            count  <= count + CNT_W'(do_push_1) + CNT_W'(do_push_2) - CNT_W'(do_pop);
        end
    end

    // a push past full or a pop from empty leaves the count out of range.
    q_no_push_full_a: assert property (
        @(posedge clk) disable iff (rst) count <= CNT_W'(`FETCH_QUEUE_DEPTH)
    );

    // pointers and count move together.
    q_no_pop_empty_a: assert property (
        @(posedge clk) disable iff (rst)
        PTR_W'(wr_ptr - rd_ptr) == count[PTR_W-1:0]
    );

endmodule

//--- verilog/fetch_top.sv
`timescale 1ns/1ps
`include "fetch_macros.svh"

module fetch_top (
    input  logic                          clk,
    input  logic                          rst,
    input  logic                          fetch_en,
    input  logic                          branch_taken,
    input  logic [31:0]                   branch_address,
    input  logic                          exception_taken,
    input  logic [31:0]                   exception_address,

    input  logic                          tlb_we,
    input  logic [`FETCH_TLB_INDEX_W-1:0] tlb_index,
    input  logic [19:0]                   tlb_vpn,
    input  logic [19:0]                   tlb_pfn,
    input  logic                          tlb_valid,
    input  logic                          tlb_cached,

    input  logic                          mem_we,
    input  logic [`FETCH_MEM_ADDR_W-1:0]  mem_addr,
    input  logic [31:0]                   mem_wdata,

    input  logic                          deq,

    output logic                          inst_valid,
    output logic [31:0]                   inst_pc,
    output logic [31:0]                   inst_word,
    output logic                          fetch_fault,
    output fetch_pkg::fault_kind_t        fault_kind,
    output logic [31:0]                   fault_address,
    output logic [31:0]                   pc_address,
    output logic                          fetch_uncached
);

    tlb_port_if bran_if ();
    tlb_port_if seq0_if ();
    tlb_port_if seq1_if ();

    fetch_pkg::tlb_entry_t tlb_entry;

    logic [31:0] pc_address_psy;
    logic        tlb_miss;
    logic        tlb_illegal;
    logic        tlb_invalid;
    logic        inst_ok_1;
    logic        inst_ok_2;
    logic        fifo_full;
    logic [31:0] inst_word_0;
    logic [31:0] inst_word_1;

    assign tlb_entry = '{vpn: tlb_vpn, pfn: tlb_pfn, valid: tlb_valid, cached: tlb_cached};
    assign fault_address = pc_address;

    pc u_pc (
        .clk               (clk),
        .rst               (rst),
        .pc_en             (fetch_en),
        .inst_ok_1         (inst_ok_1),
        .inst_ok_2         (inst_ok_2),
        .fifo_full         (fifo_full),
        .branch_taken      (branch_taken),
        .branch_address    (branch_address),
        .exception_taken   (exception_taken),
        .exception_address (exception_address),
        .bran_port         (bran_if),
        .seq0_port         (seq0_if),
        .seq1_port         (seq1_if),
        .pc_address        (pc_address),
        .pc_address_psy    (pc_address_psy),
        .tlb_miss          (tlb_miss),
        .tlb_illegal       (tlb_illegal),
        .tlb_invalid       (tlb_invalid),
        .tlb_uncached      (fetch_uncached)
    );

    itlb u_itlb (
        .clk       (clk),
        .rst       (rst),
        .we        (tlb_we),
        .index     (tlb_index),
        .entry     (tlb_entry),
        .bran_port (bran_if),
        .seq0_port (seq0_if),
        .seq1_port (seq1_if)
    );

    inst_fetch u_inst_fetch (
        .clk            (clk),
        .mem_we         (mem_we),
        .mem_addr       (mem_addr),
        .mem_wdata      (mem_wdata),
        .pc_address     (pc_address),
        .pc_address_psy (pc_address_psy),
        .tlb_miss       (tlb_miss),
        .tlb_illegal    (tlb_illegal),
        .tlb_invalid    (tlb_invalid),
        .inst_ok_1      (inst_ok_1),
        .inst_ok_2      (inst_ok_2),
        .inst_word_0    (inst_word_0),
        .inst_word_1    (inst_word_1),
        .fetch_fault    (fetch_fault),
        .fault_kind     (fault_kind)
    );

    // the queue applies its own full flag and the flush to the push requests.
    fetch_queue u_fetch_queue (
        .clk        (clk),
        .rst        (rst),
        .push_1     (fetch_en && inst_ok_1),
        .push_2     (fetch_en && inst_ok_2),
        .flush      (fetch_en && (branch_taken || exception_taken)),
        .pc_0       (pc_address),
        .word_0     (inst_word_0),
        .word_1     (inst_word_1),
        .deq        (deq),
        .fifo_full  (fifo_full),
        .inst_valid (inst_valid),
        .inst_pc    (inst_pc),
        .inst_word  (inst_word)
    );

endmodule

//--- dv/fetch_checker.sv
`timescale 1ns/1ps
`include "fetch_macros.svh"

module fetch_checker (
    input  logic                          clk,
    input  logic                          rst,
    input  logic                          fetch_en,
    input  logic                          branch_taken,
    input  logic [31:0]                   branch_address,
    input  logic                          exception_taken,
    input  logic [31:0]                   exception_address,
    input  logic                          tlb_we,
    input  logic [`FETCH_TLB_INDEX_W-1:0] tlb_index,
    input  logic [19:0]                   tlb_vpn,
    input  logic [19:0]                   tlb_pfn,
    input  logic                          tlb_valid,
    input  logic                          tlb_cached,
    input  logic                          mem_we,
    input  logic [`FETCH_MEM_ADDR_W-1:0]  mem_addr,
    input  logic [31:0]                   mem_wdata,
    input  logic                          deq,
    input  logic                          inst_valid,
    input  logic [31:0]                   inst_pc,
    input  logic [31:0]                   inst_word,
    input  logic                          fetch_fault,
    input  fetch_pkg::fault_kind_t        fault_kind,
    input  logic [31:0]                   pc_address,
    input  logic                          fetch_uncached,
    output int                            err_count,
    output int                            pop_count
);

    typedef struct packed {
        fetch_pkg::fault_kind_t kind;
        logic [31:0]            paddr;
        logic                   uncached;
    } ref_result_t;

    // model copies of memory and tlb, taken from the write ports.
    logic [31:0] mem_copy    [`FETCH_MEM_WORDS];
    logic [19:0] ref_vpn     [`FETCH_TLB_ENTRIES];
    logic [19:0] ref_pfn     [`FETCH_TLB_ENTRIES];
    logic        ref_valid   [`FETCH_TLB_ENTRIES];
    logic        ref_cached  [`FETCH_TLB_ENTRIES];
    logic        ref_written [`FETCH_TLB_ENTRIES];
    logic [31:0] exp_pc;

    initial begin
        err_count = 0;
        pop_count = 0;
    end

    function automatic ref_result_t translate_ref(input logic [31:0] va);
        ref_result_t r;
        int          hit;
        r.kind     = fetch_pkg::FAULT_NONE;
        r.paddr    = {3'b000, va[28:0]};
        r.uncached = 1'b0;
        hit        = -1;
        for (int e = 0; e < `FETCH_TLB_ENTRIES; e++) begin
            if (ref_written[e] && ref_vpn[e] == va[31:12]) hit = e;
        end
        if (va[1:0] != 2'b00) begin
            r.kind = fetch_pkg::FAULT_ILLEGAL;
        end else if (va[31:29] == `FETCH_SEG_KSEG1) begin
            r.uncached = 1'b1;
        end else if (va[31:29] == `FETCH_SEG_KSEG0) begin
            r.uncached = 1'b0;
        end else if (va[31]) begin
            // kseg2 and kseg3.
            r.kind = fetch_pkg::FAULT_ILLEGAL;
        end else if (hit < 0) begin
            r.kind = fetch_pkg::FAULT_MISS;
        end else if (!ref_valid[hit]) begin
            r.kind = fetch_pkg::FAULT_INVALID;
        end else begin
            r.paddr    = {ref_pfn[hit], va[11:0]};
            r.uncached = !ref_cached[hit];
        end
        return r;
    endfunction

    task automatic flag_mismatch(input string name, input logic [31:0] got,
                                 input logic [31:0] exp);
        $display("[ERROR] time %0t: %s is %h, expected %h", $time, name, got, exp);
        err_count++;
    endtask

    // inputs and outputs are both settled at the falling edge.
    always @(negedge clk) begin : check_cycle
        ref_result_t r;
        if (rst) begin
            exp_pc = `FETCH_RESET_PC;
            for (int e = 0; e < `FETCH_TLB_ENTRIES; e++) ref_written[e] = 1'b0;
        end else begin
            r = translate_ref(pc_address);
            if (r.kind == fetch_pkg::FAULT_NONE) begin
                if (fetch_fault !== 1'b0) flag_mismatch("fetch_fault", fetch_fault, 0);
                if (fetch_uncached !== r.uncached) begin
                    flag_mismatch("fetch_uncached", fetch_uncached, r.uncached);
                end
            end else begin
                if (fetch_fault !== 1'b1) flag_mismatch("fetch_fault", fetch_fault, 1);
                if (fault_kind !== r.kind) flag_mismatch("fault_kind", fault_kind, r.kind);
            end
            // pop happens at the next rising edge.
            if (deq && inst_valid) begin
                r = translate_ref(exp_pc);
                if (inst_pc !== exp_pc) flag_mismatch("inst_pc", inst_pc, exp_pc);
                if (inst_word !== mem_copy[r.paddr[`FETCH_MEM_ADDR_W+1:2]]) begin
                    flag_mismatch("inst_word", inst_word,
                                  mem_copy[r.paddr[`FETCH_MEM_ADDR_W+1:2]]);
                end
                exp_pc = exp_pc + 32'd4;
                pop_count++;
            end
            if (fetch_en && exception_taken) exp_pc = exception_address;
            else if (fetch_en && branch_taken) exp_pc = branch_address;
            if (tlb_we) begin
                ref_vpn[tlb_index]     = tlb_vpn;
                ref_pfn[tlb_index]     = tlb_pfn;
                ref_valid[tlb_index]   = tlb_valid;
                ref_cached[tlb_index]  = tlb_cached;
                ref_written[tlb_index] = 1'b1;
            end
        end
        if (mem_we) mem_copy[mem_addr] = mem_wdata;
    end

endmodule

//--- dv/fetch_tb.sv
`timescale 1ns/1ps
`include "fetch_macros.svh"

module fetch_tb;

    logic                          clk;
    logic                          rst;
    logic                          fetch_en;
    logic                          branch_taken;
    logic                          exception_taken;
    logic [31:0]                   branch_address;
    logic [31:0]                   exception_address;
    logic                          tlb_we;
    logic [`FETCH_TLB_INDEX_W-1:0] tlb_index;
    logic [19:0]                   tlb_vpn;
    logic [19:0]                   tlb_pfn;
    logic                          tlb_valid;
    logic                          tlb_cached;
    logic                          mem_we;
    logic [`FETCH_MEM_ADDR_W-1:0]  mem_addr;
    logic [31:0]                   mem_wdata;
    logic                          deq;

    logic                          inst_valid;
    logic [31:0]                   inst_pc;
    logic [31:0]                   inst_word;
    logic                          fetch_fault;
    fetch_pkg::fault_kind_t        fault_kind;
    logic [31:0]                   fault_address;
    logic [31:0]                   pc_address;
    logic                          fetch_uncached;

    int          tb_errors;
    int          chk_errors;
    int          pops;
    integer      seed;
    logic [31:0] held_pc;

    fetch_top dut (.*);

    fetch_checker chk (.*, .err_count(chk_errors), .pop_count(pops));

    always #2 clk = ~clk;

    task automatic step(input int n);
        repeat (n) begin
            @(posedge clk);
            #1;
        end
    endtask

    task automatic expect_eq(input string name, input logic [31:0] got,
                             input logic [31:0] exp);
        if (got !== exp) begin
            $display("[ERROR] time %0t: %s is %h, expected %h", $time, name, got, exp);
            tb_errors++;
        end
    endtask

    task automatic redirect(input logic exc, input logic [31:0] target);
        if (exc) begin
            exception_address = target;
            exception_taken   = 1'b1;
        end else begin
            branch_address = target;
            branch_taken   = 1'b1;
        end
        step(1);
        exception_taken = 1'b0;
        branch_taken    = 1'b0;
    endtask

    task automatic tlb_write(input int idx, input logic [19:0] vpn, input logic [19:0] pfn,
                             input logic valid, input logic cached);
        tlb_index  = idx;
        tlb_vpn    = vpn;
        tlb_pfn    = pfn;
        tlb_valid  = valid;
        tlb_cached = cached;
        tlb_we     = 1'b1;
        step(1);
        tlb_we = 1'b0;
    endtask

    task automatic wait_pops(input int n);
        int goal;
        int cycles;
        goal   = pops + n;
        cycles = 0;
        while (pops < goal && cycles < 200) begin
            step(1);
            cycles++;
        end
        if (pops < goal) begin
            $display("timeout: %0d instructions were not popped within 200 cycles", n);
            tb_errors++;
        end
    endtask

    task automatic wait_valid();
        int cycles;
        cycles = 0;
        while (!inst_valid && cycles < 200) begin
            step(1);
            cycles++;
        end
        if (!inst_valid) begin
            $display("timeout: the queue stayed empty for 200 cycles");
            tb_errors++;
        end
    endtask

    task automatic expect_fault(input logic [31:0] target, input fetch_pkg::fault_kind_t kind);
        int cycles;
        redirect(1'b0, target);
        cycles = 0;
        while (!fetch_fault && cycles < 200) begin
            step(1);
            cycles++;
        end
        if (!fetch_fault) begin
            $display("timeout: no fetch fault raised for %h within 200 cycles", target);
            tb_errors++;
        end
        expect_eq("fault_kind", fault_kind, kind);
        expect_eq("fault_address", fault_address, target);
        // a faulting fetch pushes nothing and holds the pc.
        step(3);
        expect_eq("inst_valid", inst_valid, 1'b0);
        expect_eq("pc_address", pc_address, target);
    endtask

    initial begin
        clk = 1'b0;
        rst = 1'b1;
        seed = 98;
        tb_errors = 0;
        fetch_en = 1'b0;
        branch_taken = 1'b0;
        exception_taken = 1'b0;
        branch_address = '0;
        exception_address = '0;
        tlb_we = 1'b0;
        tlb_index = '0;
        tlb_vpn = '0;
        tlb_pfn = '0;
        tlb_valid = 1'b0;
        tlb_cached = 1'b0;
        mem_we = 1'b0;
        mem_addr = '0;
        mem_wdata = '0;
        deq = 1'b0;

        // memory load starts while reset is still held.
        fork
            begin
                step(10);
                rst = 1'b0;
            end
            begin
                step(1);
                for (int i = 0; i < `FETCH_MEM_WORDS; i++) begin
                    mem_addr  = i;
                    mem_wdata = $random(seed);
                    mem_we    = 1'b1;
                    step(1);
                end
                mem_we = 1'b0;
            end
        join

        expect_eq("pc_address", pc_address, `FETCH_RESET_PC);
        expect_eq("fetch_uncached", fetch_uncached, 1'b1);
        expect_eq("inst_valid", inst_valid, 1'b0);
        expect_eq("fetch_fault", fetch_fault, 1'b0);

        // kseg1 from reset, then kseg0.
        fetch_en = 1'b1;
        deq = 1'b1;
        wait_pops(40);
        redirect(1'b0, 32'h8000_0100);
        wait_pops(40);
        expect_eq("fetch_uncached", fetch_uncached, 1'b0);

        deq = 1'b0;
        step(30);
        held_pc = pc_address;
        step(3);
        expect_eq("pc_address", pc_address, held_pc);
        expect_eq("inst_valid", inst_valid, 1'b1);
        deq = 1'b1;
        wait_pops(20);

        deq = 1'b0;
        step(5);
        redirect(1'b0, 32'h8000_0200);
        wait_valid();
        expect_eq("inst_pc", inst_pc, 32'h8000_0200);
        deq = 1'b1;
        wait_pops(10);

        // mapped pages, the run crosses from vpn 400 into 401.
        tlb_write(0, 20'h00400, 20'h00012, 1'b1, 1'b1);
        tlb_write(1, 20'h00401, 20'h00013, 1'b1, 1'b0);
        tlb_write(2, 20'h00500, 20'h00014, 1'b0, 1'b1);
        redirect(1'b0, 32'h0040_0fc0);
        wait_pops(40);

        expect_fault(32'h0060_0000, fetch_pkg::FAULT_MISS);
        expect_fault(32'h0050_0000, fetch_pkg::FAULT_INVALID);
        expect_fault(32'hc000_0000, fetch_pkg::FAULT_ILLEGAL);
        redirect(1'b1, 32'hbfc0_0040);
        wait_pops(20);
        expect_eq("fetch_fault", fetch_fault, 1'b0);

        step(2);
        $display("errors: checker %0d, testbench %0d", chk_errors, tb_errors);
        if (chk_errors == 0 && tb_errors == 0) begin
            $display("All tests passed");
        end else begin
            $display("Some tests failed");
        end
        $finish;
    end

endmodule

//--- sim.f
+incdir+verilog
verilog/fetch_pkg.sv
verilog/tlb_port_if.sv
verilog/pc.sv
verilog/itlb.sv
verilog/inst_fetch.sv
verilog/fetch_queue.sv
verilog/fetch_top.sv
dv/fetch_checker.sv
dv/fetch_tb.sv
